//--- Bender.yml
package:
  name: npc

sources:
  - design/npcPkg.sv
  - design/npcRegFile.sv
  - design/npcDecoder.sv
  - design/npcExecute.sv
  - design/npcLoadStore.sv
  - design/npcSequencer.sv
  - design/npcTop.sv
  - target: test
    files:
      - test/npcTop_properties.sv
      - test/npcTb.sv

//--- design/npcDecoder.sv
`timescale 1ns/1ps

module npcDecoder
  import npcPkg::*;
(
  input  logic [InstWidth-1:0]    inst,
  output logic [RegAddrWidth-1:0] rs1,
  output logic [RegAddrWidth-1:0] rs2,
  output logic [RegAddrWidth-1:0] rd,
  output logic [2:0]              funct3,
  output logic                    funct7Alt,
  output instClassT               instClass,
  output logic [XLEN-1:0]         imm
);

  logic [6:0]      opcode;
  logic [XLEN-1:0] immI;
  logic [XLEN-1:0] immS;
  logic [XLEN-1:0] immB;
  logic [XLEN-1:0] immU;
  logic [XLEN-1:0] immJ;

  assign opcode = inst[6:0];
  assign rd     = inst[11:7];
  assign funct3 = inst[14:12];
  assign rs1    = inst[19:15];
  assign rs2    = inst[24:20];

  assign immI = {{(XLEN-12){inst[31]}}, inst[31:20]};
  assign immS = {{(XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
  assign immB = {{(XLEN-13){inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign immU = {{(XLEN-32){inst[31]}}, inst[31:12], 12'b0};
  assign immJ = {{(XLEN-21){inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    case (opcode)
      OpLui:    instClass = ClsLui;
      OpAuipc:  instClass = ClsAuipc;
      OpJal:    instClass = ClsJal;
      OpJalr:   instClass = ClsJalr;
      OpBranch: instClass = ClsBranch;
      OpLoad:   instClass = ClsLoad;
      OpStore:  instClass = ClsStore;
      OpImm:    instClass = ClsImm;
      OpReg:    instClass = ClsReg;
      default:  instClass = ClsNone;
    endcase
  end

  always_comb begin
    case (instClass)
      ClsJalr, ClsLoad, ClsImm: imm = immI;
      ClsStore:                 imm = immS;
      ClsBranch:                imm = immB;
      ClsLui, ClsAuipc:         imm = immU;
      ClsJal:                   imm = immJ;
      default:                  imm = '0;
    endcase
  end

  // shamt is 6 bits on RV64, so SRAI only has funct6
  always_comb begin
    case (instClass)
      ClsReg:  funct7Alt = (inst[31:25] == F7Alt);
      ClsImm:  funct7Alt = (funct3 == F3Srl) && (inst[31:26] == F7Alt[6:1]);
      default: funct7Alt = 1'b0;
    endcase
  end

endmodule

//--- design/npcExecute.sv
`timescale 1ns/1ps

module npcExecute
  import npcPkg::*;
(
  input  logic [XLEN-1:0] pc,
  input  instClassT       instClass,
  input  logic [2:0]      funct3,
  input  logic            funct7Alt,
  input  logic [XLEN-1:0] imm,
  input  logic [XLEN-1:0] rs1Data,
  input  logic [XLEN-1:0] rs2Data,
  input  logic [XLEN-1:0] loadData,
  output logic [XLEN-1:0] nextPc,
  output logic [XLEN-1:0] memAddr,
  output logic            rdWrite,
  output logic [XLEN-1:0] rdResult
);

  logic [XLEN-1:0] aluB;
  logic [XLEN:0]   diff;
  logic [XLEN-1:0] sum;
  logic [5:0]      shamt;
  logic            ltu;
  logic            lt;
  logic            eq;
  logic [XLEN-1:0] sraResult;
  logic [XLEN-1:0] aluResult;
  logic            taken;
  logic [XLEN-1:0] pcPlus4;
  logic [XLEN-1:0] pcImm;
  logic [XLEN-1:0] rs1Imm;

  // branches compare against rs2 like register ops
  assign aluB = (instClass == ClsReg || instClass == ClsBranch) ? rs2Data : imm;

  // extra top bit of the difference is the unsigned borrow
  assign diff  = {1'b0, rs1Data} - {1'b0, aluB};
  assign sum   = rs1Data + aluB;
  assign shamt = aluB[5:0];
  assign ltu   = diff[XLEN];
  assign lt    = (rs1Data[XLEN-1] != aluB[XLEN-1]) ? rs1Data[XLEN-1] : diff[XLEN-1];
  assign eq    = (diff[XLEN-1:0] == '0);

  // arithmetic shift kept apart so the sign fill survives
  assign sraResult = $signed(rs1Data) >>> shamt;

  always_comb begin
    case (funct3)
      F3Add:   aluResult = funct7Alt ? diff[XLEN-1:0] : sum;
      F3Sll:   aluResult = rs1Data << shamt;
      F3Slt:   aluResult = {{(XLEN-1){1'b0}}, lt};
      F3Sltu:  aluResult = {{(XLEN-1){1'b0}}, ltu};
      F3Xor:   aluResult = rs1Data ^ aluB;
      F3Srl:   aluResult = funct7Alt ? sraResult : rs1Data >> shamt;
      F3Or:    aluResult = rs1Data | aluB;
      F3And:   aluResult = rs1Data & aluB;
      default: aluResult = '0;
    endcase
  end

  always_comb begin
    case (funct3)
      F3Beq:   taken = eq;
      F3Bne:   taken = !eq;
      F3Blt:   taken = lt;
      F3Bge:   taken = !lt;
      F3Bltu:  taken = ltu;
      F3Bgeu:  taken = !ltu;
      default: taken = 1'b0;
    endcase
  end

  assign pcPlus4 = pc + XLEN'(4);
  assign pcImm   = pc + imm;
  // JALR target and load/store address share this adder
  assign rs1Imm  = rs1Data + imm;
  assign memAddr = rs1Imm;

  always_comb begin
    if (instClass == ClsJal || (instClass == ClsBranch && taken)) begin
      nextPc = pcImm;
    end else if (instClass == ClsJalr) begin
      nextPc = {rs1Imm[XLEN-1:1], 1'b0};
    end else begin
      nextPc = pcPlus4;
    end
  end

  always_comb begin
    case (instClass)
      ClsLui:          rdResult = imm;
      ClsAuipc:        rdResult = pcImm;
      ClsJal, ClsJalr: rdResult = pcPlus4;
      ClsLoad:         rdResult = loadData;
      default:         rdResult = aluResult;
    endcase
  end

  assign rdWrite = (instClass == ClsLui) || (instClass == ClsAuipc) ||
                   (instClass == ClsJal) || (instClass == ClsJalr) ||
                   (instClass == ClsLoad) || (instClass == ClsImm) ||
                   (instClass == ClsReg);

endmodule

//--- design/npcLoadStore.sv
`timescale 1ns/1ps

module npcLoadStore
  import npcPkg::*;
(
  input  logic [2:0]          funct3,
  input  logic [XLEN-1:0]     memAddr,
  input  logic [XLEN-1:0]     storeData,
  input  logic [XLEN-1:0]     busRead,
  output logic [SelWidth-1:0] wbSelOut,
  output logic [XLEN-1:0]     busWrite,
  output logic [XLEN-1:0]     loadData
);

  logic [2:0]          byteOff;
  logic [5:0]          bitOff;
  logic [SelWidth-1:0] sizeMask;
  logic [XLEN-1:0]     shifted;

  assign byteOff = memAddr[2:0];
  assign bitOff  = {byteOff, 3'b000};

  // low two funct3 bits give the size for loads and stores alike
  always_comb begin
    case (funct3[1:0])
      F3Sb[1:0]: sizeMask = 8'h01;
      F3Sh[1:0]: sizeMask = 8'h03;
      F3Sw[1:0]: sizeMask = 8'h0f;
      F3Sd[1:0]: sizeMask = 8'hff;
      default:   sizeMask = 8'hff;
    endcase
  end

  assign wbSelOut = sizeMask << byteOff;
  assign busWrite = storeData << bitOff;

  // bring the addressed bytes down to lane 0
  assign shifted = busRead >> bitOff;

  always_comb begin
    case (funct3)
      F3Lb:    loadData = {{(XLEN-8){shifted[7]}}, shifted[7:0]};
      F3Lh:    loadData = {{(XLEN-16){shifted[15]}}, shifted[15:0]};
      F3Lw:    loadData = {{(XLEN-32){shifted[31]}}, shifted[31:0]};
      F3Ld:    loadData = shifted;
      F3Lbu:   loadData = {{(XLEN-8){1'b0}}, shifted[7:0]};
      F3Lhu:   loadData = {{(XLEN-16){1'b0}}, shifted[15:0]};
      F3Lwu:   loadData = {{(XLEN-32){1'b0}}, shifted[31:0]};
      default: loadData = shifted;
    endcase
  end

endmodule

//--- design/npcPkg.sv
package npcPkg;

  localparam int XLEN         = 64;
  localparam int RegAddrWidth = 5;
  localparam int InstWidth    = 32;
  localparam int SelWidth     = XLEN / 8;

  localparam logic [XLEN-1:0] ResetPc = 64'h0000_0000_8000_0000;

  // major opcodes
  localparam logic [6:0] OpLui    = 7'b0110111;
  localparam logic [6:0] OpAuipc  = 7'b0010111;
  localparam logic [6:0] OpJal    = 7'b1101111;
  localparam logic [6:0] OpJalr   = 7'b1100111;
  localparam logic [6:0] OpBranch = 7'b1100011;
  localparam logic [6:0] OpLoad   = 7'b0000011;
  localparam logic [6:0] OpStore  = 7'b0100011;
  localparam logic [6:0] OpImm    = 7'b0010011;
  localparam logic [6:0] OpReg    = 7'b0110011;

  // branch conditions
  localparam logic [2:0] F3Beq  = 3'b000;
  localparam logic [2:0] F3Bne  = 3'b001;
  localparam logic [2:0] F3Blt  = 3'b100;
  localparam logic [2:0] F3Bge  = 3'b101;
  localparam logic [2:0] F3Bltu = 3'b110;
  localparam logic [2:0] F3Bgeu = 3'b111;

  // load widths
  localparam logic [2:0] F3Lb  = 3'b000;
  localparam logic [2:0] F3Lh  = 3'b001;
  localparam logic [2:0] F3Lw  = 3'b010;
  localparam logic [2:0] F3Ld  = 3'b011;
  localparam logic [2:0] F3Lbu = 3'b100;
  localparam logic [2:0] F3Lhu = 3'b101;
  localparam logic [2:0] F3Lwu = 3'b110;

  // store widths
  localparam logic [2:0] F3Sb = 3'b000;
  localparam logic [2:0] F3Sh = 3'b001;
  localparam logic [2:0] F3Sw = 3'b010;
  localparam logic [2:0] F3Sd = 3'b011;

  // alu ops, shared by OP and OP-IMM
  localparam logic [2:0] F3Add  = 3'b000;
  localparam logic [2:0] F3Sll  = 3'b001;
  localparam logic [2:0] F3Slt  = 3'b010;
  localparam logic [2:0] F3Sltu = 3'b011;
  localparam logic [2:0] F3Xor  = 3'b100;
  localparam logic [2:0] F3Srl  = 3'b101;
  localparam logic [2:0] F3Or   = 3'b110;
  localparam logic [2:0] F3And  = 3'b111;

  // SUB / SRA
  localparam logic [6:0] F7Alt = 7'b0100000;

  typedef enum logic [3:0] {
    ClsNone,
    ClsLui,
    ClsAuipc,
    ClsJal,
    ClsJalr,
    ClsBranch,
    ClsLoad,
    ClsStore,
    ClsImm,
    ClsReg
  } instClassT;

endpackage

//--- design/npcRegFile.sv
`timescale 1ns/1ps

module npcRegFile
  import npcPkg::*;
(
  input  logic                    clk,
  input  logic [RegAddrWidth-1:0] rs1,
  input  logic [RegAddrWidth-1:0] rs2,
  input  logic [RegAddrWidth-1:0] rd,
  input  logic                    rdWen,
  input  logic [XLEN-1:0]         rdData,
  output logic [XLEN-1:0]         rs1Data,
  output logic [XLEN-1:0]         rs2Data
);

  // x1..x31 only
  logic [XLEN-1:0] regs [1:31];

  always_ff @(posedge clk) begin
    if (rdWen && (rd != '0)) begin
      regs[rd] <= rdData;
    end
  end

  // x0 reads as zero
  assign rs1Data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2Data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

//--- design/npcSequencer.sv
`timescale 1ns/1ps

module npcSequencer
  import npcPkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 isLoad,
  input  logic                 isStore,
  input  logic [XLEN-1:0]      nextPc,
  input  logic [XLEN-1:0]      memAddr,
  input  logic                 rdWrite,
  input  logic [SelWidth-1:0]  dataSel,
  input  logic [XLEN-1:0]      dataWrite,
  output logic                 wbCyc,
  output logic                 wbStb,
  output logic                 wbWe,
  output logic [XLEN-1:0]      wbAdr,
  output logic [XLEN-1:0]      wbDatW,
  output logic [SelWidth-1:0]  wbSel,
  input  logic [XLEN-1:0]      wbDatR,
  input  logic                 wbAck,
  output logic [XLEN-1:0]      pc,
  output logic [InstWidth-1:0] inst,
  output logic [XLEN-1:0]      readData,
  output logic                 rdWen
);

  typedef enum logic [1:0] {
    Fetch,
    Decode,
    Mem,
    Writeback
  } seqStateT;

  seqStateT state;

  // classic single access, strobe follows cycle
  assign wbStb = wbCyc;

  always_ff @(posedge clk) begin
    if (rst) begin
      state  <= Fetch;
      wbCyc  <= 1'b0;
      wbWe   <= 1'b0;
      wbDatW <= '0;
      pc     <= ResetPc;
    end else begin
      case (state)
        Fetch: begin
          if (!wbCyc) begin
            // first fetch out of reset
            wbCyc <= 1'b1;
            wbWe  <= 1'b0;
            wbAdr <= {pc[XLEN-1:3], 3'b000};
            wbSel <= '1;
          end else if (wbAck) begin
            wbCyc <= 1'b0;
            inst  <= pc[2] ? wbDatR[63:32] : wbDatR[31:0];
            state <= Decode;
          end
        end
        Decode: begin
          if (isLoad || isStore) begin
            wbCyc  <= 1'b1;
            wbWe   <= isStore;
            wbAdr  <= {memAddr[XLEN-1:3], 3'b000};
            wbSel  <= dataSel;
            wbDatW <= dataWrite;
            state  <= Mem;
          end else begin
            state <= Writeback;
          end
        end
        Mem: begin
          if (wbAck) begin
            wbCyc    <= 1'b0;
            wbWe     <= 1'b0;
            readData <= wbDatR;
            state    <= Writeback;
          end
        end
        Writeback: begin
          pc    <= nextPc;
          // next fetch goes out straight away
          wbCyc <= 1'b1;
          wbWe  <= 1'b0;
          wbAdr <= {nextPc[XLEN-1:3], 3'b000};
          wbSel <= '1;
          state <= Fetch;
        end
        default: begin
          state <= Fetch;
          wbCyc <= 1'b0;
        end
      endcase
    end
  end

  assign rdWen = (state == Writeback) && rdWrite;

endmodule

//--- design/npcTop.sv
`timescale 1ns/1ps

module npcTop
  import npcPkg::*;
(
  input  logic                clk,
  input  logic                rst,
  output logic                wbCyc,
  output logic                wbStb,
  output logic                wbWe,
  output logic [XLEN-1:0]     wbAdr,
  output logic [XLEN-1:0]     wbDatW,
  output logic [SelWidth-1:0] wbSel,
  input  logic [XLEN-1:0]     wbDatR,
  input  logic                wbAck,
  output logic [XLEN-1:0]     pc
);

  logic [InstWidth-1:0]    inst;
  logic [RegAddrWidth-1:0] rs1;
  logic [RegAddrWidth-1:0] rs2;
  logic [RegAddrWidth-1:0] rd;
  logic [2:0]              funct3;
  logic                    funct7Alt;
  instClassT               instClass;
  logic [XLEN-1:0]         imm;
  logic [XLEN-1:0]         rs1Data;
  logic [XLEN-1:0]         rs2Data;
  logic [XLEN-1:0]         nextPc;
  logic [XLEN-1:0]         memAddr;
  logic                    rdWrite;
  logic [XLEN-1:0]         rdResult;
  logic                    rdWen;
  logic [XLEN-1:0]         readData;
  logic [XLEN-1:0]         loadData;
  logic [SelWidth-1:0]     dataSel;
  logic [XLEN-1:0]         dataWrite;
  logic                    isLoad;
  logic                    isStore;

  assign isLoad  = (instClass == ClsLoad);
  assign isStore = (instClass == ClsStore);

  npcSequencer npcSequencer_inst (
    .clk      (clk),
    .rst      (rst),
    .isLoad   (isLoad),
    .isStore  (isStore),
    .nextPc   (nextPc),
    .memAddr  (memAddr),
    .rdWrite  (rdWrite),
    .dataSel  (dataSel),
    .dataWrite(dataWrite),
    .wbCyc    (wbCyc),
    .wbStb    (wbStb),
    .wbWe     (wbWe),
    .wbAdr    (wbAdr),
    .wbDatW   (wbDatW),
    .wbSel    (wbSel),
    .wbDatR   (wbDatR),
    .wbAck    (wbAck),
    .pc       (pc),
    .inst     (inst),
    .readData (readData),
    .rdWen    (rdWen)
  );

  npcDecoder npcDecoder_inst (
    .inst     (inst),
    .rs1      (rs1),
    .rs2      (rs2),
    .rd       (rd),
    .funct3   (funct3),
    .funct7Alt(funct7Alt),
    .instClass(instClass),
    .imm      (imm)
  );

  npcRegFile npcRegFile_inst (
    .clk    (clk),
    .rs1    (rs1),
    .rs2    (rs2),
    .rd     (rd),
    .rdWen  (rdWen),
    .rdData (rdResult),
    .rs1Data(rs1Data),
    .rs2Data(rs2Data)
  );

  npcExecute npcExecute_inst (
    .pc       (pc),
    .instClass(instClass),
    .funct3   (funct3),
    .funct7Alt(funct7Alt),
    .imm      (imm),
    .rs1Data  (rs1Data),
    .rs2Data  (rs2Data),
    .loadData (loadData),
    .nextPc   (nextPc),
    .memAddr  (memAddr),
    .rdWrite  (rdWrite),
    .rdResult (rdResult)
  );

  npcLoadStore npcLoadStore_inst (
    .funct3   (funct3),
    .memAddr  (memAddr),
    .storeData(rs2Data),
    .busRead  (readData),
    .wbSelOut (dataSel),
    .busWrite (dataWrite),
    .loadData (loadData)
  );

endmodule

//--- tb.f
design/npcPkg.sv
design/npcRegFile.sv
design/npcDecoder.sv
design/npcExecute.sv
design/npcLoadStore.sv
design/npcSequencer.sv
design/npcTop.sv
test/npcTop_properties.sv
test/npcTb.sv

//--- test/npcTb.sv
`timescale 1ns/1ps

module npcTb
  import npcPkg::*;
();

  localparam int MemWords = 1024;
  localparam int MaxCycles = 20000;

  logic                clk;
  logic                rst;
  logic                wbCyc;
  logic                wbStb;
  logic                wbWe;
  logic [XLEN-1:0]     wbAdr;
  logic [XLEN-1:0]     wbDatW;
  logic [SelWidth-1:0] wbSel;
  logic [XLEN-1:0]     wbDatR;
  logic                wbAck;
  logic [XLEN-1:0]     pc;

  logic [XLEN-1:0]     mem [0:MemWords-1];
  logic [XLEN-1:0]     asmPc;
  logic [XLEN-1:0]     haltPc;
  logic [XLEN-1:0]     base;
  logic [XLEN-1:0]     a;
  logic [XLEN-1:0]     b;
  logic [XLEN-1:0]     c;
  logic [XLEN-1:0]     d;
  logic [XLEN-1:0]     known;
  logic [XLEN-1:0]     expAdr [$];
  logic [SelWidth-1:0] expSel [$];
  logic [XLEN-1:0]     expDat [$];
  string               expName [$];
  string               curGroup;
  int                  seed;
  int                  delay;
  logic                busy;
  int                  errors;
  int                  groupErrors;
  int                  testsRun;
  int                  testsFailed;
  int                  storesSeen;
  int                  expCount;
  int                  cycles;
  int                  off;
  logic                timedOut;

  npcTop npcTop_inst (
    .clk   (clk),
    .rst   (rst),
    .wbCyc (wbCyc),
    .wbStb (wbStb),
    .wbWe  (wbWe),
    .wbAdr (wbAdr),
    .wbDatW(wbDatW),
    .wbSel (wbSel),
    .wbDatR(wbDatR),
    .wbAck (wbAck),
    .pc    (pc)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] rType(input logic [6:0] f7, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OpReg};
  endfunction

  function automatic logic [31:0] iType(input logic [11:0] imm, input logic [4:0] rs1,
      input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] sType(input logic [11:0] imm, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OpStore};
  endfunction

  function automatic logic [31:0] bType(input logic [12:0] imm, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OpBranch};
  endfunction

  function automatic logic [31:0] jType(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OpJal};
  endfunction

  task automatic emit(input logic [31:0] word);
    int idx;
    idx = (asmPc - ResetPc) >> 3;
    if (asmPc[2]) begin
      mem[idx][63:32] = word;
    end else begin
      mem[idx][31:0] = word;
    end
    asmPc = asmPc + 4;
  endtask

  task automatic expectStore(input string name, input logic [XLEN-1:0] addr,
      input int size, input logic [XLEN-1:0] value);
    logic [SelWidth-1:0] mask;
    mask = (size == 8) ? 8'hff : ((8'h01 << size) - 8'h01);
    expAdr.push_back({addr[XLEN-1:3], 3'b000});
    expSel.push_back(mask << addr[2:0]);
    expDat.push_back(value << (8 * addr[2:0]));
    expName.push_back(name);
  endtask

  // result lands in x5, then SD x5 to the result area
  task automatic aluCase(input logic [31:0] word, input logic [XLEN-1:0] value);
    emit(word);
    emit(sType(off[11:0], 5'd5, 5'd10, F3Sd));
    expectStore("alu", base + off, 8, value);
    off = off + 8;
  endtask

  task automatic loadCase(input logic [2:0] f3, input int at);
    logic [XLEN-1:0] sh;
    logic [XLEN-1:0] value;
    sh = known >> (8 * at);
    case (f3)
      F3Lb:    value = {{56{sh[7]}}, sh[7:0]};
      F3Lh:    value = {{48{sh[15]}}, sh[15:0]};
      F3Lw:    value = {{32{sh[31]}}, sh[31:0]};
      F3Lbu:   value = {56'b0, sh[7:0]};
      F3Lhu:   value = {48'b0, sh[15:0]};
      F3Lwu:   value = {32'b0, sh[31:0]};
      default: value = sh;
    endcase
    emit(iType(12'h300 + at, 5'd10, f3, 5'd6, OpLoad));
    emit(sType(off[11:0], 5'd6, 5'd10, F3Sd));
    expectStore("load", base + off, 8, value);
    off = off + 8;
  endtask

  task automatic branchCase(input logic [2:0] f3, input logic [4:0] r1, input logic [4:0] r2,
      input logic [XLEN-1:0] v1, input logic [XLEN-1:0] v2);
    logic taken;
    case (f3)
      F3Beq:   taken = (v1 == v2);
      F3Bne:   taken = (v1 != v2);
      F3Blt:   taken = ($signed(v1) < $signed(v2));
      F3Bge:   taken = ($signed(v1) >= $signed(v2));
      F3Bltu:  taken = (v1 < v2);
      default: taken = (v1 >= v2);
    endcase
    if (taken) begin
      // skips the marker store
      emit(bType(13'd8, r2, r1, f3));
      emit(sType(12'h4f8, 5'd7, 5'd10, F3Sd));
    end else begin
      emit(bType(13'd12, r2, r1, f3));
      emit(iType(off[11:0], 5'd0, F3Add, 5'd8, OpImm));
      emit(sType(off[11:0], 5'd8, 5'd10, F3Sd));
      expectStore("branch", base + off, 8, off);
      off = off + 8;
    end
  endtask

  task automatic reportGroup();
    testsRun++;
    if (groupErrors != 0) begin
      testsFailed++;
    end
    $display("test %s finished with %0d error(s)", curGroup, groupErrors);
    groupErrors = 0;
  endtask

  task automatic checkStore(input logic [XLEN-1:0] adr, input logic [SelWidth-1:0] sel,
      input logic [XLEN-1:0] dat);
    logic [XLEN-1:0] byteMask;
    logic [XLEN-1:0] eDat;
    string name;
    storesSeen++;
    if (expAdr.size() == 0) begin
      $display("unexpected store to address %h with data %h", adr, dat);
      errors++;
      groupErrors++;
    end else begin
      name = expName.pop_front();
      if (curGroup != "" && name != curGroup) begin
        reportGroup();
      end
      curGroup = name;
      for (int i = 0; i < SelWidth; i++) begin
        byteMask[8*i +: 8] = {8{sel[i]}};
      end
      eDat = expDat.pop_front();
      assert (adr == expAdr[0]) else begin
        $display("[FAIL] %s address expected %h actual %h", name, expAdr[0], adr);
        errors++;
        groupErrors++;
      end
      assert (sel == expSel[0]) else begin
        $display("[FAIL] %s select expected %h actual %h", name, expSel[0], sel);
        errors++;
        groupErrors++;
      end
      assert ((dat & byteMask) == (eDat & byteMask)) else begin
        $display("[FAIL] %s data expected %h actual %h", name, eDat & byteMask,
                 dat & byteMask);
        errors++;
        groupErrors++;
      end
      void'(expAdr.pop_front());
      void'(expSel.pop_front());
    end
  endtask

  // wishbone slave with random ack delay
  always @(negedge clk) begin
    int idx;
    if (wbAck) begin
      wbAck = 1'b0;
    end else if (wbStb && !rst) begin
      if (!busy) begin
        busy = 1'b1;
        delay = $unsigned($random(seed)) % 4;
      end
      if (delay == 0) begin
        idx = wbAdr[12:3];
        if (wbWe) begin
          for (int i = 0; i < SelWidth; i++) begin
            if (wbSel[i]) begin
              mem[idx][8*i +: 8] = wbDatW[8*i +: 8];
            end
          end
          checkStore(wbAdr, wbSel, wbDatW);
        end
        wbDatR = mem[idx];
        wbAck = 1'b1;
        busy = 1'b0;
      end else begin
        delay--;
      end
    end
  end

  initial begin
    rst = 1'b1;
    wbAck = 1'b0;
    wbDatR = '0;
    busy = 1'b0;
    seed = 32'h9f7affdd;
    errors = 0;
    groupErrors = 0;
    testsRun = 0;
    testsFailed = 0;
    storesSeen = 0;
    curGroup = "";
    timedOut = 1'b0;
    for (int i = 0; i < MemWords; i++) begin
      mem[i] = (ResetPc + 8 * i) ^ 64'h5a5a_0000_0000_0000;
    end

    base = ResetPc + 64'h1000;
    a = 64'hffff_ffff_ffff_fff9;
    b = 64'h1234_5678;
    c = 64'd37;
    d = b << 24;
    known = 64'h8192_a3b4_75d6_e7f8;
    mem[(base + 64'h300 - ResetPc) >> 3] = known;

    asmPc = ResetPc;
    emit({20'h00001, 5'd10, OpAuipc});
    emit(iType(-12'sd7, 5'd0, F3Add, 5'd1, OpImm));
    emit({20'h12345, 5'd2, OpLui});
    emit(iType(12'h678, 5'd2, F3Add, 5'd2, OpImm));
    emit(iType(12'd37, 5'd0, F3Add, 5'd3, OpImm));
    emit(iType(12'd24, 5'd2, F3Sll, 5'd4, OpImm));
    emit(iType(12'h666, 5'd0, F3Add, 5'd7, OpImm));

    off = 0;
    aluCase(rType(7'h00, 5'd2, 5'd1, F3Add, 5'd5), a + b);
    aluCase(rType(F7Alt, 5'd2, 5'd1, F3Add, 5'd5), a - b);
    aluCase(rType(7'h00, 5'd3, 5'd2, F3Sll, 5'd5), b << c);
    aluCase(rType(7'h00, 5'd2, 5'd1, F3Slt, 5'd5), 64'd1);
    aluCase(rType(7'h00, 5'd2, 5'd1, F3Sltu, 5'd5), 64'd0);
    aluCase(rType(7'h00, 5'd4, 5'd1, F3Xor, 5'd5), a ^ d);
    aluCase(rType(7'h00, 5'd3, 5'd1, F3Srl, 5'd5), a >> c);
    aluCase(rType(F7Alt, 5'd3, 5'd1, F3Srl, 5'd5), $signed(a) >>> c);
    aluCase(rType(7'h00, 5'd4, 5'd2, F3Or, 5'd5), b | d);
    aluCase(rType(7'h00, 5'd4, 5'd1, F3And, 5'd5), a & d);
    aluCase(iType(-12'sd100, 5'd2, F3Add, 5'd5, OpImm), b - 64'd100);
    aluCase(iType(-12'sd6, 5'd1, F3Slt, 5'd5, OpImm), 64'd1);
    aluCase(iType(-12'sd1, 5'd2, F3Sltu, 5'd5, OpImm), 64'd1);
    aluCase(iType(12'h555, 5'd1, F3Xor, 5'd5, OpImm), a ^ 64'h555);
    aluCase(iType(-12'sd256, 5'd2, F3Or, 5'd5, OpImm), b | 64'hffff_ffff_ffff_ff00);
    aluCase(iType(12'h0f0, 5'd2, F3And, 5'd5, OpImm), b & 64'hf0);
    aluCase(iType(12'd40, 5'd2, F3Sll, 5'd5, OpImm), b << 40);
    aluCase(iType(12'd33, 5'd1, F3Srl, 5'd5, OpImm), a >> 33);
    aluCase(iType(12'h400 | 12'd33, 5'd1, F3Srl, 5'd5, OpImm), $signed(a) >>> 33);

    // one store width per word, each at a different lane
    emit(sType(12'h203, 5'd2, 5'd10, F3Sb));
    expectStore("lanes", base + 64'h203, 1, b);
    emit(sType(12'h20e, 5'd2, 5'd10, F3Sh));
    expectStore("lanes", base + 64'h20e, 2, b);
    emit(sType(12'h214, 5'd2, 5'd10, F3Sw));
    expectStore("lanes", base + 64'h214, 4, b);
    emit(sType(12'h218, 5'd2, 5'd10, F3Sd));
    expectStore("lanes", base + 64'h218, 8, b);

    off = 'h380;
    loadCase(F3Lb, 0);
    loadCase(F3Lb, 7);
    loadCase(F3Lbu, 7);
    loadCase(F3Lh, 2);
    loadCase(F3Lh, 6);
    loadCase(F3Lhu, 6);
    loadCase(F3Lw, 0);
    loadCase(F3Lw, 4);
    loadCase(F3Lwu, 4);
    loadCase(F3Ld, 0);

    off = 'h400;
    branchCase(F3Beq, 5'd1, 5'd1, a, a);
    branchCase(F3Beq, 5'd1, 5'd2, a, b);
    branchCase(F3Bne, 5'd1, 5'd2, a, b);
    branchCase(F3Bne, 5'd1, 5'd1, a, a);
    branchCase(F3Blt, 5'd1, 5'd2, a, b);
    branchCase(F3Blt, 5'd2, 5'd1, b, a);
    branchCase(F3Bge, 5'd2, 5'd1, b, a);
    branchCase(F3Bge, 5'd1, 5'd2, a, b);
    branchCase(F3Bltu, 5'd2, 5'd1, b, a);
    branchCase(F3Bltu, 5'd1, 5'd2, a, b);
    branchCase(F3Bgeu, 5'd1, 5'd2, a, b);
    branchCase(F3Bgeu, 5'd2, 5'd1, b, a);

    // link registers must hold the jump's pc plus 4
    expectStore("jump", base + 64'h480, 8, asmPc + 4);
    emit(jType(21'd8, 5'd9));
    emit(sType(12'h4f8, 5'd7, 5'd10, F3Sd));
    emit(sType(12'h480, 5'd9, 5'd10, F3Sd));
    expectStore("jump", base + 64'h488, 8, asmPc + 8);
    emit({20'h00000, 5'd11, OpAuipc});
    emit(iType(12'd16, 5'd11, 3'b000, 5'd9, OpJalr));
    emit(sType(12'h4f8, 5'd7, 5'd10, F3Sd));
    emit(sType(12'h4f8, 5'd7, 5'd10, F3Sd));
    emit(sType(12'h488, 5'd9, 5'd10, F3Sd));
    // program parks on a jump to itself
    haltPc = asmPc;
    emit(jType(21'd0, 5'd0));
    expCount = expAdr.size();

    for (int i = 0; i < 16; i++) begin
      @(negedge clk);
      assert (!wbCyc) else begin
        $display("bus cycle started during reset");
        groupErrors++;
        errors++;
      end
    end
    rst = 1'b0;

    curGroup = "reset";
    assert (!wbCyc && pc == ResetPc) else begin
      $display("[FAIL] reset pc expected %h actual %h, cyc %b", ResetPc, pc, wbCyc);
      groupErrors++;
      errors++;
    end
    cycles = 0;
    while (!wbCyc && cycles < 100) begin
      @(negedge clk);
      cycles++;
    end
    assert (wbCyc && wbAdr == {ResetPc[XLEN-1:3], 3'b000} && wbSel == '1 && !wbWe)
      else begin
        $display("[FAIL] reset first fetch expected adr %h actual adr %h sel %h we %b",
                 ResetPc, wbAdr, wbSel, wbWe);
        groupErrors++;
        errors++;
      end
    reportGroup();
    curGroup = "";

    cycles = 0;
    while (pc != haltPc && cycles < MaxCycles) begin
      @(negedge clk);
      cycles++;
    end
    if (pc != haltPc) begin
      timedOut = 1'b1;
      $display("timeout waiting for the final jump, pc %h, saw %0d of %0d stores",
               pc, storesSeen, expCount);
    end else if (expAdr.size() != 0) begin
      $display("%0d of %0d expected stores never appeared", expAdr.size(), expCount);
      groupErrors++;
      errors++;
    end
    if (curGroup != "") begin
      reportGroup();
    end
    $display("tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, errors);
    if (errors == 0 && !timedOut) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

//--- test/npcTop_properties.sv
`timescale 1ns/1ps

module npcTopProperties
  import npcPkg::*;
(
  input logic                clk,
  input logic                rst,
  input logic                wbCyc,
  input logic                wbStb,
  input logic                wbWe,
  input logic [XLEN-1:0]     wbAdr,
  input logic [XLEN-1:0]     wbDatW,
  input logic [SelWidth-1:0] wbSel,
  input logic                wbAck,
  input logic [XLEN-1:0]     pc
);

  // bus idle and pc at the reset vector on the first cycle out of reset
  idleAfterReset: assert property (@(posedge clk)
    $fell(rst) |-> (!wbCyc && !wbStb && !wbWe && pc == ResetPc))
    else $error("bus active or pc off the reset vector on the first cycle after reset");

  // request held until the slave answers
  holdRequest: assert property (@(posedge clk) disable iff (rst)
    (wbStb && !wbAck) |=> (wbStb && $stable(wbAdr) && $stable(wbSel) &&
                           $stable(wbWe) && $stable(wbDatW)))
    else $error("bus request changed while waiting for ack");

  dropAfterAck: assert property (@(posedge clk) disable iff (rst)
    (wbStb && wbAck) |=> !wbStb)
    else $error("strobe still high on the cycle after ack");

  pcHeld: assert property (@(posedge clk) disable iff (rst)
    (wbStb && !wbAck) |=> $stable(pc))
    else $error("pc moved while an access was outstanding");

endmodule

bind npcTop npcTopProperties npcTopProperties_inst (.*);
